// File: run.sh
#!/bin/sh
# build and run the csr testbench with verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module csr_tb -f tb.f \
  && ./obj_dir/Vcsr_tb > sim.log 2>&1 \
  || echo "build or simulation exited with an error"
cat sim.log 2>/dev/null
grep -qx "Verification passed" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }

// File: source/csr_apb_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_defines.svh"

module csr_apb_port (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 psel_i,
  input  logic                 penable_i,
  input  logic                 pwrite_i,
  input  logic [15:0]          paddr_i,
  input  csr_pkg::word_t       pwdata_i,
  input  csr_pkg::excp_view_t  excp_view_i,
  input  csr_pkg::timer_view_t timer_view_i,
  input  csr_pkg::plain_view_t plain_view_i,
  output csr_pkg::csr_wr_t     csr_wr_o,
  output csr_pkg::word_t       prdata_o,
  output logic                 pready_o
);

  import csr_pkg::*;

  csr_num_t num;
  logic     rd_access;
  logic     pready_q;

  // word addressed
  assign num = paddr_i[15:2];

  assign csr_wr_o.valid = psel_i && penable_i && pwrite_i;
  assign csr_wr_o.num   = num;
  assign csr_wr_o.data  = pwdata_i;

  assign rd_access = psel_i && penable_i && !pwrite_i;

  always_comb begin
    prdata_o = '0;
    if (rd_access) begin
      case (num)
        `CSR_CRMD:   prdata_o = excp_view_i.crmd;
        `CSR_PRMD:   prdata_o = excp_view_i.prmd;
        `CSR_ECTL:   prdata_o = excp_view_i.ectl;
        `CSR_ESTAT:  prdata_o = excp_view_i.estat;
        `CSR_ERA:    prdata_o = excp_view_i.era;
        `CSR_BADV:   prdata_o = excp_view_i.badv;
        `CSR_EENTRY: prdata_o = plain_view_i.eentry;
        `CSR_SAVE0:  prdata_o = plain_view_i.save0;
        `CSR_SAVE1:  prdata_o = plain_view_i.save1;
        `CSR_SAVE2:  prdata_o = plain_view_i.save2;
        `CSR_SAVE3:  prdata_o = plain_view_i.save3;
        `CSR_TID:    prdata_o = plain_view_i.tid;
        `CSR_TCFG:   prdata_o = timer_view_i.tcfg;
        `CSR_TVAL:   prdata_o = timer_view_i.tval;
        `CSR_CNTL:   prdata_o = timer_view_i.cnt[31:0];
        `CSR_CNTH:   prdata_o = timer_view_i.cnt[63:32];
        // ticlr and unmapped numbers read zero
        default:     prdata_o = '0;
      endcase
    end
  end

  // no wait states, ready once out of reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pready_q <= 1'b0;
    end else begin
      pready_q <= 1'b1;
    end
  end

  assign pready_o = pready_q;

  // access phase only inside a selected transfer
  a_penable_needs_psel: assert property (
    @(posedge clk) disable iff (!rst_n)
    penable_i |-> psel_i
  );

endmodule

`default_nettype wire

// File: source/csr_defines.svh
`ifndef CSR_DEFINES_SVH
`define CSR_DEFINES_SVH

`define CSR_NUM_W 14
`define HW_INT_W 8

// csr numbers
`define CSR_CRMD   14'h000
`define CSR_PRMD   14'h001
`define CSR_ECTL   14'h004
`define CSR_ESTAT  14'h005
`define CSR_ERA    14'h006
`define CSR_BADV   14'h007
`define CSR_EENTRY 14'h00c
`define CSR_SAVE0  14'h030
`define CSR_SAVE1  14'h031
`define CSR_SAVE2  14'h032
`define CSR_SAVE3  14'h033
`define CSR_TID    14'h040
`define CSR_TCFG   14'h041
`define CSR_TVAL   14'h042
`define CSR_TICLR  14'h044

// stable counter words, not architectural csrs
`define CSR_CNTL   14'h060
`define CSR_CNTH   14'h061

`define CRMD_PLV 1:0
`define CRMD_IE  2
`define CRMD_DA  3
`define CRMD_PG  4

`define PRMD_PPLV 1:0
`define PRMD_PIE  2

`define ESTAT_SWI      1:0
`define ESTAT_HWI      9:2
`define ESTAT_TI       11
`define ESTAT_IS       12:0
`define ESTAT_ECODE    21:16
`define ESTAT_ESUBCODE 30:22

`define ECTL_LIE 12:0

`define TCFG_EN       0
`define TCFG_PERIODIC 1
`define TCFG_INITVAL  31:2

`define TICLR_CLR 0

`define EENTRY_VA 31:6

`define CRMD_RESET   32'h0000_0008
`define TVAL_EXPIRED 32'hffff_ffff

`endif

// File: source/csr_excp_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_defines.svh"

module csr_excp_regs (
  input  logic                 clk,
  input  logic                 rst_n,
  input  csr_pkg::csr_wr_t     csr_wr_i,
  input  csr_pkg::excp_event_t excp_i,
  input  logic                 ertn_i,
  input  csr_pkg::hw_int_t     hw_int_i,
  input  logic                 timer_irq_i,
  output csr_pkg::excp_view_t  excp_view_o,
  output csr_pkg::plv_t        plv_o,
  output logic                 ie_o,
  output csr_pkg::word_t       era_o,
  output logic                 irq_o
);

  import csr_pkg::*;

  word_t     crmd_q;
  word_t     prmd_q;
  word_t     ectl_q;
  word_t     era_q;
  word_t     badv_q;
  logic [1:0] swi_q;
  hw_int_t   hwi_q;
  ecode_t    ecode_q;
  esubcode_t esubcode_q;
  word_t     estat;

  logic crmd_we;
  logic prmd_we;
  logic ectl_we;
  logic estat_we;
  logic era_we;
  logic badv_we;

  assign crmd_we  = csr_wr_i.valid && (csr_wr_i.num == `CSR_CRMD);
  assign prmd_we  = csr_wr_i.valid && (csr_wr_i.num == `CSR_PRMD);
  assign ectl_we  = csr_wr_i.valid && (csr_wr_i.num == `CSR_ECTL);
  assign estat_we = csr_wr_i.valid && (csr_wr_i.num == `CSR_ESTAT);
  assign era_we   = csr_wr_i.valid && (csr_wr_i.num == `CSR_ERA);
  assign badv_we  = csr_wr_i.valid && (csr_wr_i.num == `CSR_BADV);

  // crmd and prmd, bus write last so it wins
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      crmd_q <= `CRMD_RESET;
      prmd_q <= '0;
    end else begin
      if (excp_i.valid) begin
        prmd_q[`PRMD_PPLV] <= crmd_q[`CRMD_PLV];
        prmd_q[`PRMD_PIE]  <= crmd_q[`CRMD_IE];
        crmd_q[`CRMD_PLV]  <= '0;
        crmd_q[`CRMD_IE]   <= 1'b0;
      end
      if (ertn_i) begin
        crmd_q[`CRMD_PLV] <= prmd_q[`PRMD_PPLV];
        crmd_q[`CRMD_IE]  <= prmd_q[`PRMD_PIE];
      end
      if (crmd_we) begin
        crmd_q[`CRMD_PLV] <= csr_wr_i.data[`CRMD_PLV];
        crmd_q[`CRMD_IE]  <= csr_wr_i.data[`CRMD_IE];
        crmd_q[`CRMD_DA]  <= csr_wr_i.data[`CRMD_DA];
        crmd_q[`CRMD_PG]  <= csr_wr_i.data[`CRMD_PG];
      end
      if (prmd_we) begin
        prmd_q[`PRMD_PPLV] <= csr_wr_i.data[`PRMD_PPLV];
        prmd_q[`PRMD_PIE]  <= csr_wr_i.data[`PRMD_PIE];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ectl_q     <= '0;
      swi_q      <= '0;
      hwi_q      <= '0;
      ecode_q    <= '0;
      esubcode_q <= '0;
    end else begin
      // hardware lines sampled every cycle
      hwi_q <= hw_int_i;
      if (excp_i.valid) begin
        ecode_q    <= excp_i.ecode;
        esubcode_q <= excp_i.esubcode;
      end
      if (estat_we) begin
        swi_q <= csr_wr_i.data[`ESTAT_SWI];
      end
      if (ectl_we) begin
        ectl_q[`ECTL_LIE] <= csr_wr_i.data[`ECTL_LIE];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (excp_i.valid) begin
      era_q <= excp_i.era;
    end
    if (excp_i.valid && excp_i.badv_valid) begin
      badv_q <= excp_i.badv;
    end
    if (era_we) begin
      era_q <= csr_wr_i.data;
    end
    if (badv_we) begin
      badv_q <= csr_wr_i.data;
    end
  end

  always_comb begin
    estat                  = '0;
    estat[`ESTAT_SWI]      = swi_q;
    estat[`ESTAT_HWI]      = hwi_q;
    estat[`ESTAT_TI]       = timer_irq_i;
    estat[`ESTAT_ECODE]    = ecode_q;
    estat[`ESTAT_ESUBCODE] = esubcode_q;
  end

  assign irq_o = crmd_q[`CRMD_IE] && |(estat[`ESTAT_IS] & ectl_q[`ECTL_LIE]);

  assign plv_o = crmd_q[`CRMD_PLV];
  assign ie_o  = crmd_q[`CRMD_IE];
  assign era_o = era_q;

  assign excp_view_o.crmd  = crmd_q;
  assign excp_view_o.prmd  = prmd_q;
  assign excp_view_o.ectl  = ectl_q;
  assign excp_view_o.estat = estat;
  assign excp_view_o.era   = era_q;
  assign excp_view_o.badv  = badv_q;

  // pipeline never retires a trap and an ertn together
  a_no_excp_with_ertn: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(excp_i.valid && ertn_i)
  );

endmodule

`default_nettype wire

// File: source/csr_pkg.sv
`default_nettype none

`include "csr_defines.svh"

package csr_pkg;

  typedef logic [`CSR_NUM_W-1:0] csr_num_t;
  typedef logic [31:0]           word_t;
  typedef logic [1:0]            plv_t;
  typedef logic [5:0]            ecode_t;
  typedef logic [8:0]            esubcode_t;
  typedef logic [`HW_INT_W-1:0]  hw_int_t;

  // one whole-word write from the bus
  typedef struct packed {
    logic     valid;
    csr_num_t num;
    word_t    data;
  } csr_wr_t;

  typedef struct packed {
    logic      valid;
    ecode_t    ecode;
    esubcode_t esubcode;
    word_t     era;
    word_t     badv;
    logic      badv_valid;
  } excp_event_t;

  typedef struct packed {
    word_t crmd;
    word_t prmd;
    word_t ectl;
    word_t estat;
    word_t era;
    word_t badv;
  } excp_view_t;

  typedef struct packed {
    word_t       tcfg;
    word_t       tval;
    logic        ti;
    logic [63:0] cnt;
  } timer_view_t;

  typedef struct packed {
    word_t eentry;
    word_t save0;
    word_t save1;
    word_t save2;
    word_t save3;
    word_t tid;
  } plain_view_t;

  // what the core pipeline needs
  typedef struct packed {
    plv_t  plv;
    logic  ie;
    word_t era;
    word_t eentry;
    logic  irq;
  } core_csr_t;

endpackage

`default_nettype wire

// File: source/csr_plain_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_defines.svh"

module csr_plain_regs (
  input  logic                 clk,
  input  logic                 rst_n,
  input  csr_pkg::csr_wr_t     csr_wr_i,
  output csr_pkg::plain_view_t plain_view_o,
  output csr_pkg::word_t       eentry_o
);

  import csr_pkg::*;

  logic [31:6] eentry_va_q;
  word_t       save_q [4];
  word_t       tid_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      eentry_va_q <= '0;
      tid_q       <= '0;
    end else if (csr_wr_i.valid) begin
      if (csr_wr_i.num == `CSR_EENTRY) begin
        eentry_va_q <= csr_wr_i.data[`EENTRY_VA];
      end
      if (csr_wr_i.num == `CSR_TID) begin
        tid_q <= csr_wr_i.data;
      end
    end
  end

  // save0 to save3 sit at consecutive numbers
  always_ff @(posedge clk) begin
    for (int i = 0; i < 4; i++) begin
      if (!rst_n) begin
        save_q[i] <= '0;
      end else if (csr_wr_i.valid && (csr_wr_i.num == csr_num_t'(`CSR_SAVE0 + i))) begin
        save_q[i] <= csr_wr_i.data;
      end
    end
  end

  // entry is 64-byte aligned
  assign eentry_o = {eentry_va_q, 6'b0};

  assign plain_view_o.eentry = eentry_o;
  assign plain_view_o.save0  = save_q[0];
  assign plain_view_o.save1  = save_q[1];
  assign plain_view_o.save2  = save_q[2];
  assign plain_view_o.save3  = save_q[3];
  assign plain_view_o.tid    = tid_q;

endmodule

`default_nettype wire

// File: source/csr_timer.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_defines.svh"

module csr_timer (
  input  logic                 clk,
  input  logic                 rst_n,
  input  csr_pkg::csr_wr_t     csr_wr_i,
  output csr_pkg::timer_view_t timer_view_o
);

  import csr_pkg::*;

  word_t       tcfg_q;
  word_t       tval_q;
  logic        en_q;
  logic        ti_q;
  logic [63:0] cnt_q;
  logic        tcfg_we;
  logic        ticlr_clr;
  logic        expire;

  assign tcfg_we   = csr_wr_i.valid && (csr_wr_i.num == `CSR_TCFG);
  assign ticlr_clr = csr_wr_i.valid && (csr_wr_i.num == `CSR_TICLR)
                     && csr_wr_i.data[`TICLR_CLR];

  // a tcfg write restarts the countdown instead
  assign expire = en_q && (tval_q == '0) && !tcfg_we;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tcfg_q <= '0;
      tval_q <= '0;
      en_q   <= 1'b0;
    end else if (tcfg_we) begin
      tcfg_q <= csr_wr_i.data;
      tval_q <= {csr_wr_i.data[`TCFG_INITVAL], 2'b00};
      en_q   <= csr_wr_i.data[`TCFG_EN];
    end else if (en_q) begin
      if (tval_q != '0) begin
        tval_q <= tval_q - 32'd1;
      end else if (tcfg_q[`TCFG_PERIODIC]) begin
        tval_q <= {tcfg_q[`TCFG_INITVAL], 2'b00};
      end else begin
        // one-shot stops and parks at all ones
        en_q   <= 1'b0;
        tval_q <= `TVAL_EXPIRED;
      end
    end
  end

  // clear beats set
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ti_q <= 1'b0;
    end else if (ticlr_clr) begin
      ti_q <= 1'b0;
    end else if (expire) begin
      ti_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + 64'd1;
    end
  end

  assign timer_view_o.tcfg = tcfg_q;
  assign timer_view_o.tval = tval_q;
  assign timer_view_o.ti   = ti_q;
  assign timer_view_o.cnt  = cnt_q;

  // tval never counts down while stopped
  a_tval_frozen_when_off: assert property (
    @(posedge clk) disable iff (!rst_n)
    !en_q |=> (tval_q != $past(tval_q) - 32'd1)
  );

endmodule

`default_nettype wire

// File: source/csr_top.sv
`timescale 1ns/1ps
`default_nettype none

module csr_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 psel_i,
  input  logic                 penable_i,
  input  logic                 pwrite_i,
  input  logic [15:0]          paddr_i,
  input  csr_pkg::word_t       pwdata_i,
  input  csr_pkg::excp_event_t excp_i,
  input  logic                 ertn_i,
  input  csr_pkg::hw_int_t     hw_int_i,
  output csr_pkg::word_t       prdata_o,
  output logic                 pready_o,
  output csr_pkg::core_csr_t   core_csr_o
);

  import csr_pkg::*;

  csr_wr_t     csr_wr;
  excp_view_t  excp_view;
  timer_view_t timer_view;
  plain_view_t plain_view;
  plv_t        plv;
  logic        ie;
  word_t       era;
  word_t       eentry;
  logic        irq;

  csr_apb_port u_apb_port (
    .clk          (clk),
    .rst_n        (rst_n),
    .psel_i       (psel_i),
    .penable_i    (penable_i),
    .pwrite_i     (pwrite_i),
    .paddr_i      (paddr_i),
    .pwdata_i     (pwdata_i),
    .excp_view_i  (excp_view),
    .timer_view_i (timer_view),
    .plain_view_i (plain_view),
    .csr_wr_o     (csr_wr),
    .prdata_o     (prdata_o),
    .pready_o     (pready_o)
  );

  csr_excp_regs u_excp_regs (
    .clk         (clk),
    .rst_n       (rst_n),
    .csr_wr_i    (csr_wr),
    .excp_i      (excp_i),
    .ertn_i      (ertn_i),
    .hw_int_i    (hw_int_i),
    .timer_irq_i (timer_view.ti),
    .excp_view_o (excp_view),
    .plv_o       (plv),
    .ie_o        (ie),
    .era_o       (era),
    .irq_o       (irq)
  );

  csr_timer u_timer (
    .clk          (clk),
    .rst_n        (rst_n),
    .csr_wr_i     (csr_wr),
    .timer_view_o (timer_view)
  );

  csr_plain_regs u_plain_regs (
    .clk          (clk),
    .rst_n        (rst_n),
    .csr_wr_i     (csr_wr),
    .plain_view_o (plain_view),
    .eentry_o     (eentry)
  );

  assign core_csr_o.plv    = plv;
  assign core_csr_o.ie     = ie;
  assign core_csr_o.era    = era;
  assign core_csr_o.eentry = eentry;
  assign core_csr_o.irq    = irq;

endmodule

`default_nettype wire

// File: tb.f
+incdir+source
source/csr_pkg.sv
source/csr_apb_port.sv
source/csr_excp_regs.sv
source/csr_timer.sv
source/csr_plain_regs.sv
source/csr_top.sv
test/tb_clock.sv
test/csr_tb.sv

// File: test/csr_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_defines.svh"

module csr_tb;

  import csr_pkg::*;

  localparam int CLK_PERIOD = 100;
  // roughly 250 cycles of tests, wide margin
  localparam int WATCHDOG_CYCLES = 3000;
  localparam logic [31:0] LFSR_SEED = 32'h15ac_08f9;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  localparam csr_num_t ZERO_NUMS [12] = '{
    `CSR_PRMD, `CSR_ECTL, `CSR_ESTAT, `CSR_TCFG, `CSR_TVAL, `CSR_EENTRY,
    `CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3, `CSR_TID, `CSR_TICLR
  };
  localparam csr_num_t PLAIN_NUMS [5] = '{
    `CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3, `CSR_TID
  };

  logic        clk;
  logic        rst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [15:0] paddr;
  word_t       pwdata;
  excp_event_t excp;
  logic        ertn;
  hw_int_t     hw_int;
  word_t       prdata;
  logic        pready;
  core_csr_t   core_csr;

  logic [31:0] lfsr_state;
  int          err_count;
  int          check_count;
  int          cycle_cnt;

  tb_clock #(.PERIOD_NS(CLK_PERIOD)) u_clock (.clk_o(clk));

  csr_top dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .psel_i     (psel),
    .penable_i  (penable),
    .pwrite_i   (pwrite),
    .paddr_i    (paddr),
    .pwdata_i   (pwdata),
    .excp_i     (excp),
    .ertn_i     (ertn),
    .hw_int_i   (hw_int),
    .prdata_o   (prdata),
    .pready_o   (pready),
    .core_csr_o (core_csr)
  );

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // galois lfsr, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        bit_out;
    val = '0;
    for (int i = 0; i < n; i++) begin
      bit_out = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (bit_out) begin
        lfsr_state = lfsr_state ^ LFSR_TAPS;
      end
      val = {val[30:0], bit_out};
    end
    return val;
  endfunction

  task automatic compare_word(input string name, input word_t got, input word_t exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  // setup, access, then back to idle
  task automatic transfer(input csr_num_t num, input logic write, input word_t data,
                          output word_t rdata);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = {num, 2'b00};
    pwdata  = data;
    @(negedge clk);
    penable = 1'b1;
    #(CLK_PERIOD / 10);
    rdata = prdata;
    compare_word("pready_o", {31'b0, pready}, 32'h1);
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic write_csr(input csr_num_t num, input word_t data);
    word_t unused;
    transfer(num, 1'b1, data, unused);
  endtask

  task automatic read_csr(input csr_num_t num, output word_t data);
    transfer(num, 1'b0, 32'h0, data);
  endtask

  task automatic expect_csr(input csr_num_t num, input word_t exp);
    word_t got;
    read_csr(num, got);
    compare_word($sformatf("prdata_o csr 0x%03h", num), got, exp);
  endtask

  task automatic expect_irq(input logic exp);
    compare_word("core_csr_o.irq", {31'b0, core_csr.irq}, {31'b0, exp});
  endtask

  task automatic reset_values();
    // first edge with rst_n high takes the block out of reset
    @(negedge clk);
    compare_word("prdata_o", prdata, 32'h0);
    compare_word("pready_o", {31'b0, pready}, 32'h1);
    expect_irq(1'b0);
    expect_csr(`CSR_CRMD, 32'h0000_0008);
    for (int i = 0; i < 12; i++) begin
      expect_csr(ZERO_NUMS[i], 32'h0);
    end
  endtask

  task automatic plain_regs_rw();
    word_t vals [5];
    word_t entry;
    for (int i = 0; i < 5; i++) begin
      vals[i] = rand_bits(32);
      write_csr(PLAIN_NUMS[i], vals[i]);
    end
    for (int i = 0; i < 5; i++) begin
      expect_csr(PLAIN_NUMS[i], vals[i]);
    end
    entry = rand_bits(32);
    write_csr(`CSR_EENTRY, entry);
    expect_csr(`CSR_EENTRY, {entry[31:6], 6'b0});
    compare_word("core_csr_o.eentry", core_csr.eentry, {entry[31:6], 6'b0});
  endtask

  task automatic exception_return();
    logic [31:0] raw;
    ecode_t      ecode;
    esubcode_t   esub;
    word_t       era_val;
    word_t       badv_val;
    word_t       val;
    raw      = rand_bits(6);
    ecode    = raw[5:0];
    raw      = rand_bits(9);
    esub     = raw[8:0];
    era_val  = rand_bits(32);
    badv_val = rand_bits(32);
    // plv 3, interrupts on, direct address
    write_csr(`CSR_CRMD, 32'h0000_000f);
    @(negedge clk);
    excp.valid      = 1'b1;
    excp.ecode      = ecode;
    excp.esubcode   = esub;
    excp.era        = era_val;
    excp.badv       = badv_val;
    excp.badv_valid = 1'b1;
    @(negedge clk);
    excp = '0;
    read_csr(`CSR_CRMD, val);
    compare_word("CRMD.PLV", {30'b0, val[`CRMD_PLV]}, 32'h0);
    compare_word("CRMD.IE", {31'b0, val[`CRMD_IE]}, 32'h0);
    read_csr(`CSR_PRMD, val);
    compare_word("PRMD.PPLV", {30'b0, val[`PRMD_PPLV]}, 32'h3);
    compare_word("PRMD.PIE", {31'b0, val[`PRMD_PIE]}, 32'h1);
    read_csr(`CSR_ESTAT, val);
    compare_word("ESTAT.ECODE", {26'b0, val[`ESTAT_ECODE]}, {26'b0, ecode});
    compare_word("ESTAT.ESUBCODE", {23'b0, val[`ESTAT_ESUBCODE]}, {23'b0, esub});
    expect_csr(`CSR_ERA, era_val);
    expect_csr(`CSR_BADV, badv_val);
    compare_word("core_csr_o.era", core_csr.era, era_val);
    compare_word("core_csr_o.plv", {30'b0, core_csr.plv}, 32'h0);
    @(negedge clk);
    ertn = 1'b1;
    @(negedge clk);
    ertn = 1'b0;
    read_csr(`CSR_CRMD, val);
    compare_word("CRMD.PLV", {30'b0, val[`CRMD_PLV]}, 32'h3);
    compare_word("CRMD.IE", {31'b0, val[`CRMD_IE]}, 32'h1);
    compare_word("core_csr_o.plv", {30'b0, core_csr.plv}, 32'h3);
    compare_word("core_csr_o.ie", {31'b0, core_csr.ie}, 32'h1);
  endtask

  task automatic timer_countdown();
    word_t tval;
    word_t prev;
    word_t estat_val;
    logic  fired;
    int    start;
    // one-shot, initval 8, enabled
    write_csr(`CSR_TCFG, (32'd8 << 2) | 32'h1);
    start = cycle_cnt;
    prev  = 32'd8 << 2;
    fired = 1'b0;
    while (!fired && (cycle_cnt - start) < 64) begin
      read_csr(`CSR_TVAL, tval);
      // all ones is the parked value after expiry
      if (tval != 32'hffff_ffff) begin
        if (tval > prev) begin
          err_count++;
          $display("[ERROR] TVAL: got 0x%08h after 0x%08h, expected no increase", tval, prev);
        end
        check_count++;
        prev = tval;
      end
      read_csr(`CSR_ESTAT, estat_val);
      fired = estat_val[`ESTAT_TI];
    end
    if (!fired) begin
      err_count++;
      $display("timer interrupt bit was not set within 64 cycles of the TCFG write");
    end
    expect_csr(`CSR_TVAL, 32'hffff_ffff);
    write_csr(`CSR_TICLR, 32'h1);
    read_csr(`CSR_ESTAT, estat_val);
    compare_word("ESTAT.TI", {31'b0, estat_val[`ESTAT_TI]}, 32'h0);
  endtask

  task automatic interrupt_pending();
    write_csr(`CSR_CRMD, 32'h0000_0008);
    expect_irq(1'b0);
    write_csr(`CSR_ESTAT, 32'h1);
    expect_irq(1'b0);
    write_csr(`CSR_ECTL, 32'h1);
    expect_irq(1'b0);
    write_csr(`CSR_CRMD, 32'h0000_000c);
    expect_irq(1'b1);
    write_csr(`CSR_CRMD, 32'h0000_0008);
    expect_irq(1'b0);
    // now through hardware line 0, estat bit 2
    write_csr(`CSR_ESTAT, 32'h0);
    write_csr(`CSR_ECTL, 32'h4);
    write_csr(`CSR_CRMD, 32'h0000_000c);
    expect_irq(1'b0);
    @(negedge clk);
    hw_int = 8'h01;
    @(negedge clk);
    expect_irq(1'b1);
    hw_int = '0;
  endtask

  task automatic stable_counter();
    word_t first;
    word_t second;
    read_csr(`CSR_CNTL, first);
    repeat (4) @(negedge clk);
    read_csr(`CSR_CNTL, second);
    check_count++;
    if (second <= first) begin
      err_count++;
      $display("[ERROR] counter low word: got 0x%08h after 0x%08h, expected an increase",
               second, first);
    end
    expect_csr(`CSR_CNTH, 32'h0);
  endtask

  initial begin
    lfsr_state  = LFSR_SEED;
    err_count   = 0;
    check_count = 0;
    cycle_cnt   = 0;
    rst_n       = 1'b0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    excp        = '0;
    ertn        = 1'b0;
    hw_int      = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    reset_values();
    plain_regs_rw();
    exception_return();
    timer_countdown();
    interrupt_pending();
    stable_counter();

    $display("checks: %0d, errors: %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles before the tests finished", WATCHDOG_CYCLES);
    $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: test/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int PERIOD_NS = 100
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
  end

  always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

`default_nettype wire
